// ==== hw/mci_params.svh ====
////////////////////
// Widths and source counts shared by the error and watchdog block
// The fatal and non-fatal counts must match the field count of the
// status structs in mci_pkg
////////////////////

`ifndef MCI_PARAMS_SVH
`define MCI_PARAMS_SVH

////////////////////
// Watchdog
////////////////////

// Width of each timer counter and of each period value
`define MCI_WDT_CNT_W 16

////////////////////
// Error sources
////////////////////

// Number of external aggregate error lines per severity
`define MCI_AGG_W 8

// Hardware error sources captured in the sticky status
`define MCI_HW_FATAL_W 3
`define MCI_HW_NON_FATAL_W 2

`endif

// ==== hw/mci_pkg.sv ====
////////////////////
// Types for the error and watchdog block
// Widths come from mci_params.svh
////////////////////

`include "mci_params.svh"

package mci_pkg;

  // Counter or period value of one watchdog timer
  typedef logic [`MCI_WDT_CNT_W-1:0] wdt_cnt_t;

  // External aggregate error lines, or their mask
  typedef logic [`MCI_AGG_W-1:0] agg_err_t;

  // Hardware fatal sources, used for sources, status, clear and mask
  typedef struct packed {
    logic nmi_pin;
    logic sram_ecc_unc;
    logic dmi_axi_collision;
  } hw_fatal_t;

  // Hardware non-fatal sources
  typedef struct packed {
    logic mbox0_ecc_unc;
    logic mbox1_ecc_unc;
  } hw_non_fatal_t;

  ////////////////////
  // Watchdog
  ////////////////////

  // Static configuration, t2_en selects independent mode
  typedef struct packed {
    logic     t1_en;
    logic     t2_en;
    wdt_cnt_t t1_period;
    wdt_cnt_t t2_period;
  } wdt_cfg_t;

  // One-cycle pulses from firmware
  typedef struct packed {
    logic t1_restart;
    logic t2_restart;
    logic t1_service;
    logic t2_service;
  } wdt_ctl_t;

  // Timeout flags, also reused as the watchdog mask
  typedef struct packed {
    logic t1_timeout;
    logic t2_timeout;
  } wdt_status_t;

  typedef enum logic [1:0] {
    T2_IDLE,
    T2_RUN,
    T2_EXPIRED
  } wdt_t2_state_e;

endpackage

// ==== hw/mci_wdt.sv ====
`timescale 1ns/1ps
////////////////////
// Two watchdog timers, cascade mode when t2_en is clear
// A timeout stays set until its service pulse, restarts are ignored meanwhile
// A timer flags a timeout period + 1 edges after it starts counting from zero
////////////////////

module mci_wdt
  import mci_pkg::*;
(
  input  logic        core_clk_i,
  input  logic        rst_n_i,
  input  wdt_cfg_t    wdt_cfg_i,
  input  wdt_ctl_t    wdt_ctl_i,
  output wdt_status_t wdt_status_o
);

  // Timer 1
  logic          t1_timeout_q;
  wdt_cnt_t      t1_cnt_q;
  logic          t1_run;
  logic          t1_hit;

  // Timer 2
  wdt_t2_state_e t2_state_q;
  wdt_t2_state_e t2_state_d;
  wdt_cnt_t      t2_cnt_q;
  wdt_cnt_t      t2_cnt_d;
  logic          t2_indep;
  logic          t2_hit;

  ////////////////////
  // Timer 1
  ////////////////////

  // Timer 1 only counts while enabled and not yet expired
  assign t1_run = wdt_cfg_i.t1_en & ~t1_timeout_q;
  assign t1_hit = t1_run & (t1_cnt_q == wdt_cfg_i.t1_period);

  always_ff @(posedge core_clk_i) begin
    if (!rst_n_i) begin
      t1_timeout_q <= 1'b0;
      t1_cnt_q     <= '0;
    end else if (wdt_ctl_i.t1_service) begin
      // Service clears the timeout and starts a fresh period
      t1_timeout_q <= 1'b0;
      t1_cnt_q     <= '0;
    end else if (wdt_ctl_i.t1_restart && !t1_timeout_q) begin
      t1_cnt_q <= '0;
    end else if (t1_hit) begin
      // Count holds at the period once expired
      t1_timeout_q <= 1'b1;
    end else if (t1_run) begin
      t1_cnt_q <= t1_cnt_q + wdt_cnt_t'(1);
    end
  end

  ////////////////////
  // Timer 2
  ////////////////////

  assign t2_indep = wdt_cfg_i.t2_en;
  assign t2_hit   = (t2_cnt_q == wdt_cfg_i.t2_period);

  always_comb begin
    t2_state_d = t2_state_q;
    t2_cnt_d   = t2_cnt_q;

    if (wdt_ctl_i.t2_service) begin
      // In cascade mode timer 2 waits for the next timer 1 expiry
      t2_state_d = t2_indep ? T2_RUN : T2_IDLE;
      t2_cnt_d   = '0;
    end else begin
      unique case (t2_state_q)
        T2_IDLE: begin
          // Start on our own enable, or on the timer 1 expiry in cascade mode
          if (t2_indep || t1_timeout_q) begin
            t2_state_d = T2_RUN;
            t2_cnt_d   = '0;
          end
        end

        T2_RUN: begin
          if (wdt_ctl_i.t2_restart) begin
            t2_cnt_d = '0;
          end else if (t2_hit) begin
            t2_state_d = T2_EXPIRED;
          end else begin
            t2_cnt_d = t2_cnt_q + wdt_cnt_t'(1);
          end
        end

        T2_EXPIRED: begin
          // Sticky until serviced, restarts have no effect here
          t2_state_d = T2_EXPIRED;
        end

        default: begin
          t2_state_d = T2_IDLE;
          t2_cnt_d   = '0;
        end
      endcase
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (!rst_n_i) begin
      t2_state_q <= T2_IDLE;
      t2_cnt_q   <= '0;
    end else begin
      t2_state_q <= t2_state_d;
      t2_cnt_q   <= t2_cnt_d;
    end
  end

  ////////////////////
  // Status
  ////////////////////

  // Both flags come straight from registers
  assign wdt_status_o.t1_timeout = t1_timeout_q;
  assign wdt_status_o.t2_timeout = (t2_state_q == T2_EXPIRED);

endmodule

// ==== hw/mci_err_capture.sv ====
`timescale 1ns/1ps
////////////////////
// Sticky hardware error status with write-one-to-clear pulses
// A set and a clear in the same cycle leave the bit set
// No masking here, the status shows every event
////////////////////

`include "mci_params.svh"

module mci_err_capture
  import mci_pkg::*;
(
  input  logic          core_clk_i,
  input  logic          rst_n_i,

  input  hw_fatal_t     hw_fatal_src_i,
  input  hw_fatal_t     hw_fatal_clr_i,
  input  hw_non_fatal_t hw_non_fatal_src_i,
  input  hw_non_fatal_t hw_non_fatal_clr_i,

  output hw_fatal_t     hw_fatal_status_o,
  output hw_non_fatal_t hw_non_fatal_status_o
);

  logic [`MCI_HW_FATAL_W-1:0]     fatal_q;
  logic [`MCI_HW_FATAL_W-1:0]     fatal_d;
  logic [`MCI_HW_NON_FATAL_W-1:0] non_fatal_q;
  logic [`MCI_HW_NON_FATAL_W-1:0] non_fatal_d;

  ////////////////////
  // Next status
  ////////////////////

  // Clear first, then OR in new events so the set wins
  assign fatal_d = (fatal_q & ~hw_fatal_clr_i) | hw_fatal_src_i;

  assign non_fatal_d = (non_fatal_q & ~hw_non_fatal_clr_i) |
                       hw_non_fatal_src_i;

  ////////////////////
  // Status registers
  ////////////////////

  always_ff @(posedge core_clk_i) begin
    if (!rst_n_i) begin
      fatal_q     <= '0;
      non_fatal_q <= '0;
    end else begin
      fatal_q     <= fatal_d;
      non_fatal_q <= non_fatal_d;
    end
  end

  // Bit order follows the struct fields in mci_pkg
  assign hw_fatal_status_o     = hw_fatal_t'(fatal_q);
  assign hw_non_fatal_status_o = hw_non_fatal_t'(non_fatal_q);

endmodule

// ==== hw/mci_err_agg.sv ====
`timescale 1ns/1ps
////////////////////
// Masked OR of all error sources into two registered summary bits
// A mask bit of 1 suppresses its source
// Latency is one edge from any input level to the summary outputs
////////////////////

`include "mci_params.svh"

module mci_err_agg
  import mci_pkg::*;
(
  input  logic          core_clk_i,
  input  logic          rst_n_i,

  input  wdt_status_t   wdt_status_i,
  input  wdt_status_t   wdt_mask_i,
  input  hw_fatal_t     hw_fatal_status_i,
  input  hw_fatal_t     hw_fatal_mask_i,
  input  hw_non_fatal_t hw_non_fatal_status_i,
  input  hw_non_fatal_t hw_non_fatal_mask_i,
  input  agg_err_t      agg_fatal_i,
  input  agg_err_t      agg_fatal_mask_i,
  input  agg_err_t      agg_non_fatal_i,
  input  agg_err_t      agg_non_fatal_mask_i,

  output logic          all_error_fatal_o,
  output logic          all_error_non_fatal_o
);

  logic [`MCI_HW_FATAL_W-1:0]     hw_fatal_hit;
  logic [`MCI_HW_NON_FATAL_W-1:0] hw_non_fatal_hit;
  agg_err_t                       agg_fatal_hit;
  agg_err_t                       agg_non_fatal_hit;
  logic                           wdt_fatal_hit;
  logic                           wdt_non_fatal_hit;
  logic                           fatal_d;
  logic                           non_fatal_d;

  ////////////////////
  // Masking
  ////////////////////

  assign hw_fatal_hit     = hw_fatal_status_i & ~hw_fatal_mask_i;
  assign hw_non_fatal_hit = hw_non_fatal_status_i & ~hw_non_fatal_mask_i;

  assign agg_fatal_hit     = agg_fatal_i & ~agg_fatal_mask_i;
  assign agg_non_fatal_hit = agg_non_fatal_i & ~agg_non_fatal_mask_i;

  // Timer 2 expiry is fatal, timer 1 expiry only non-fatal
  assign wdt_fatal_hit     = wdt_status_i.t2_timeout & ~wdt_mask_i.t2_timeout;
  assign wdt_non_fatal_hit = wdt_status_i.t1_timeout & ~wdt_mask_i.t1_timeout;

  assign fatal_d     = (|hw_fatal_hit) | wdt_fatal_hit | (|agg_fatal_hit);
  assign non_fatal_d = (|hw_non_fatal_hit) | wdt_non_fatal_hit | (|agg_non_fatal_hit);

  ////////////////////
  // Summary registers
  ////////////////////

  always_ff @(posedge core_clk_i) begin
    if (!rst_n_i) begin
      all_error_fatal_o     <= 1'b0;
      all_error_non_fatal_o <= 1'b0;
    end else begin
      all_error_fatal_o     <= fatal_d;
      all_error_non_fatal_o <= non_fatal_d;
    end
  end

endmodule

// ==== hw/mci_top.sv ====
`timescale 1ns/1ps
////////////////////
// Error and watchdog block, one clock and one synchronous reset
// Configuration arrives as levels, firmware actions as one-cycle pulses
////////////////////

module mci_top
  import mci_pkg::*;
(
  input  logic          core_clk_i,
  input  logic          rst_n_i,

  // Watchdog
  input  wdt_cfg_t      wdt_cfg_i,
  input  wdt_ctl_t      wdt_ctl_i,
  input  wdt_status_t   wdt_mask_i,

  // Hardware error sources
  input  hw_fatal_t     hw_fatal_src_i,
  input  hw_fatal_t     hw_fatal_clr_i,
  input  hw_fatal_t     hw_fatal_mask_i,
  input  hw_non_fatal_t hw_non_fatal_src_i,
  input  hw_non_fatal_t hw_non_fatal_clr_i,
  input  hw_non_fatal_t hw_non_fatal_mask_i,

  // External aggregate lines
  input  agg_err_t      agg_fatal_i,
  input  agg_err_t      agg_fatal_mask_i,
  input  agg_err_t      agg_non_fatal_i,
  input  agg_err_t      agg_non_fatal_mask_i,

  output wdt_status_t   wdt_status_o,
  output hw_fatal_t     hw_fatal_status_o,
  output hw_non_fatal_t hw_non_fatal_status_o,
  output logic          all_error_fatal_o,
  output logic          all_error_non_fatal_o
);

  wdt_status_t   wdt_status;
  hw_fatal_t     hw_fatal_status;
  hw_non_fatal_t hw_non_fatal_status;

  mci_wdt u_mci_wdt (
    .core_clk_i   (core_clk_i),
    .rst_n_i      (rst_n_i),
    .wdt_cfg_i    (wdt_cfg_i),
    .wdt_ctl_i    (wdt_ctl_i),
    .wdt_status_o (wdt_status)
  );

  mci_err_capture u_mci_err_capture (
    .core_clk_i            (core_clk_i),
    .rst_n_i               (rst_n_i),
    .hw_fatal_src_i        (hw_fatal_src_i),
    .hw_fatal_clr_i        (hw_fatal_clr_i),
    .hw_non_fatal_src_i    (hw_non_fatal_src_i),
    .hw_non_fatal_clr_i    (hw_non_fatal_clr_i),
    .hw_fatal_status_o     (hw_fatal_status),
    .hw_non_fatal_status_o (hw_non_fatal_status)
  );

  mci_err_agg u_mci_err_agg (
    .core_clk_i            (core_clk_i),
    .rst_n_i               (rst_n_i),
    .wdt_status_i          (wdt_status),
    .wdt_mask_i            (wdt_mask_i),
    .hw_fatal_status_i     (hw_fatal_status),
    .hw_fatal_mask_i       (hw_fatal_mask_i),
    .hw_non_fatal_status_i (hw_non_fatal_status),
    .hw_non_fatal_mask_i   (hw_non_fatal_mask_i),
    .agg_fatal_i           (agg_fatal_i),
    .agg_fatal_mask_i      (agg_fatal_mask_i),
    .agg_non_fatal_i       (agg_non_fatal_i),
    .agg_non_fatal_mask_i  (agg_non_fatal_mask_i),
    .all_error_fatal_o     (all_error_fatal_o),
    .all_error_non_fatal_o (all_error_non_fatal_o)
  );

  assign wdt_status_o          = wdt_status;
  assign hw_fatal_status_o     = hw_fatal_status;
  assign hw_non_fatal_status_o = hw_non_fatal_status;

endmodule

// ==== bench/mci_tb_clk.sv ====
`timescale 1ns/1ps
////////////////////
// Free-running testbench clock, starts low
// The period is in ns and should be even
////////////////////

module mci_tb_clk #(
  parameter int period_ns = 4
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(period_ns / 2) clk_o = ~clk_o;
  end

endmodule

// ==== bench/mci_tb.sv ====
`timescale 1ns/1ps
////////////////////
// Table-driven testbench for mci_top
// Inputs change and outputs are checked on the falling edge
// Pulses in a step last one cycle and levels hold for the whole step
////////////////////

module mci_tb
  import mci_pkg::*;
();

  localparam int clk_period_ns = 4;

  // One row of the stimulus and expected-value table
  typedef struct packed {
    logic [2:0]    test_id;
    logic [15:0]   wait_cycles;
    wdt_cfg_t      cfg;
    wdt_ctl_t      ctl;
    wdt_status_t   wdt_mask;
    hw_fatal_t     fatal_src;
    hw_fatal_t     fatal_clr;
    hw_fatal_t     fatal_mask;
    hw_non_fatal_t nf_src;
    hw_non_fatal_t nf_clr;
    hw_non_fatal_t nf_mask;
    agg_err_t      agg_f;
    agg_err_t      agg_f_mask;
    agg_err_t      agg_nf;
    agg_err_t      agg_nf_mask;
    wdt_status_t   exp_wdt;
    hw_fatal_t     exp_fatal;
    hw_non_fatal_t exp_nf;
    logic          exp_all_f;
    logic          exp_all_nf;
  } step_t;

  logic          core_clk;
  logic          rst_n;
  wdt_cfg_t      cfg;
  wdt_ctl_t      ctl;
  wdt_status_t   wdt_mask;
  hw_fatal_t     fatal_src;
  hw_fatal_t     fatal_clr;
  hw_fatal_t     fatal_mask;
  hw_non_fatal_t nf_src;
  hw_non_fatal_t nf_clr;
  hw_non_fatal_t nf_mask;
  agg_err_t      agg_f;
  agg_err_t      agg_f_mask;
  agg_err_t      agg_nf;
  agg_err_t      agg_nf_mask;
  wdt_status_t   wdt_status;
  hw_fatal_t     fatal_status;
  hw_non_fatal_t nf_status;
  logic          all_fatal;
  logic          all_nf;

  step_t         step_q[$];
  step_t         step_r;
  int            cur_test;
  int            total_cycles;
  logic          table_built;
  logic [31:0]   lcg_state;
  int            err_cnt;
  int            check_cnt;
  int            test_errs;
  int            test_checks;
  int            test_cnt;
  int            failed_tests;

  mci_tb_clk #(.period_ns(clk_period_ns)) u_clk (.clk_o(core_clk));

  mci_top u_mci_top (
    .core_clk_i            (core_clk),
    .rst_n_i               (rst_n),
    .wdt_cfg_i             (cfg),
    .wdt_ctl_i             (ctl),
    .wdt_mask_i            (wdt_mask),
    .hw_fatal_src_i        (fatal_src),
    .hw_fatal_clr_i        (fatal_clr),
    .hw_fatal_mask_i       (fatal_mask),
    .hw_non_fatal_src_i    (nf_src),
    .hw_non_fatal_clr_i    (nf_clr),
    .hw_non_fatal_mask_i   (nf_mask),
    .agg_fatal_i           (agg_f),
    .agg_fatal_mask_i      (agg_f_mask),
    .agg_non_fatal_i       (agg_nf),
    .agg_non_fatal_mask_i  (agg_nf_mask),
    .wdt_status_o          (wdt_status),
    .hw_fatal_status_o     (fatal_status),
    .hw_non_fatal_status_o (nf_status),
    .all_error_fatal_o     (all_fatal),
    .all_error_non_fatal_o (all_nf)
  );

  ////////////////////
  // Helpers
  ////////////////////

  function automatic agg_err_t next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[23:16];
  endfunction

  // Any aggregate line left unmasked raises the summary
  function automatic logic masked_any(input agg_err_t lines, input agg_err_t mask);
    return |(lines & ~mask);
  endfunction

  function automatic string test_name(input int id);
    case (id)
      0: return "reset state";
      1: return "cascade timeout";
      2: return "pet keeps timers quiet";
      3: return "sticky capture and w1c";
      4: return "summary from hw errors";
      default: return "external aggregate lines";
    endcase
  endfunction

  task automatic expect_outputs(input wdt_status_t w, input hw_fatal_t f,
                                input hw_non_fatal_t nf, input logic sum_f,
                                input logic sum_nf);
    step_r.exp_wdt    = w;
    step_r.exp_fatal  = f;
    step_r.exp_nf     = nf;
    step_r.exp_all_f  = sum_f;
    step_r.exp_all_nf = sum_nf;
  endtask

  // Levels carry over to the next row but pulses do not
  task automatic push_step(input int waits);
    step_r.test_id     = 3'(cur_test);
    step_r.wait_cycles = 16'(waits);
    step_q.push_back(step_r);
    total_cycles += waits;
    step_r.ctl       = '0;
    step_r.fatal_src = '0;
    step_r.fatal_clr = '0;
    step_r.nf_src    = '0;
    step_r.nf_clr    = '0;
  endtask

  task automatic build_table();
    int p;
    int r;
    step_r = '0;
    cur_test = 0;
    expect_outputs(2'b00, 3'b000, 2'b00, 1'b0, 1'b0);
    push_step(1);

    // Cascade mode with t1 period 5 and t2 period 3
    // Status order is {t1, t2}
    cur_test = 1;
    step_r.cfg.t1_en      = 1'b1;
    step_r.cfg.t1_period  = 16'd5;
    step_r.cfg.t2_period  = 16'd3;
    step_r.ctl.t1_restart = 1'b1;
    expect_outputs(2'b00, 3'b000, 2'b00, 1'b0, 1'b0);
    push_step(6);
    expect_outputs(2'b10, 3'b000, 2'b00, 1'b0, 1'b0);
    push_step(1);
    expect_outputs(2'b10, 3'b000, 2'b00, 1'b0, 1'b1);
    push_step(4);
    expect_outputs(2'b11, 3'b000, 2'b00, 1'b0, 1'b1);
    push_step(1);
    step_r.ctl.t1_service = 1'b1;
    step_r.ctl.t2_service = 1'b1;
    expect_outputs(2'b00, 3'b000, 2'b00, 1'b1, 1'b1);
    push_step(1);
    step_r.cfg = '0;
    expect_outputs(2'b00, 3'b000, 2'b00, 1'b0, 1'b0);
    push_step(2);

    // Independent mode with both timers petted every 4 cycles
    cur_test = 2;
    step_r.cfg.t1_en     = 1'b1;
    step_r.cfg.t2_en     = 1'b1;
    step_r.cfg.t1_period = 16'd6;
    step_r.cfg.t2_period = 16'd6;
    for (p = 0; p < 10; p++) begin
      step_r.ctl.t1_restart = 1'b1;
      step_r.ctl.t2_restart = 1'b1;
      push_step(4);
    end
    push_step(3);
    expect_outputs(2'b11, 3'b000, 2'b00, 1'b0, 1'b0);
    push_step(1);
    // Service in cascade mode so timer 2 parks in idle
    // Timer 2 is masked so only the timer 1 expiry reaches the summary
    step_r.wdt_mask       = 2'b01;
    step_r.cfg.t1_en      = 1'b0;
    step_r.cfg.t2_en      = 1'b0;
    step_r.ctl.t1_service = 1'b1;
    step_r.ctl.t2_service = 1'b1;
    expect_outputs(2'b00, 3'b000, 2'b00, 1'b0, 1'b1);
    push_step(1);
    step_r.cfg      = '0;
    step_r.wdt_mask = '0;
    expect_outputs(2'b00, 3'b000, 2'b00, 1'b0, 1'b0);
    push_step(1);

    // The fatal summary stays masked while the status is checked
    cur_test = 3;
    step_r.fatal_mask        = 3'b111;
    step_r.fatal_src.nmi_pin = 1'b1;
    expect_outputs(2'b00, 3'b100, 2'b00, 1'b0, 1'b0);
    push_step(1);
    push_step(10);
    step_r.fatal_clr.nmi_pin = 1'b1;
    expect_outputs(2'b00, 3'b000, 2'b00, 1'b0, 1'b0);
    push_step(1);
    step_r.fatal_src.nmi_pin = 1'b1;
    step_r.fatal_clr.nmi_pin = 1'b1;
    expect_outputs(2'b00, 3'b100, 2'b00, 1'b0, 1'b0);
    push_step(1);
    step_r.fatal_clr.nmi_pin = 1'b1;
    expect_outputs(2'b00, 3'b000, 2'b00, 1'b0, 1'b0);
    push_step(1);

    // Non-fatal order is {mbox0, mbox1}
    cur_test = 4;
    step_r.fatal_mask          = '0;
    step_r.nf_src.mbox0_ecc_unc = 1'b1;
    expect_outputs(2'b00, 3'b000, 2'b10, 1'b0, 1'b0);
    push_step(1);
    expect_outputs(2'b00, 3'b000, 2'b10, 1'b0, 1'b1);
    push_step(1);
    step_r.nf_clr.mbox0_ecc_unc = 1'b1;
    expect_outputs(2'b00, 3'b000, 2'b00, 1'b0, 1'b1);
    push_step(1);
    expect_outputs(2'b00, 3'b000, 2'b00, 1'b0, 1'b0);
    push_step(1);
    step_r.nf_mask.mbox0_ecc_unc = 1'b1;
    step_r.nf_src.mbox0_ecc_unc  = 1'b1;
    expect_outputs(2'b00, 3'b000, 2'b10, 1'b0, 1'b0);
    push_step(2);
    step_r.nf_clr.mbox0_ecc_unc = 1'b1;
    expect_outputs(2'b00, 3'b000, 2'b00, 1'b0, 1'b0);
    push_step(1);
    // The mbox0 mask must not hide mbox1
    step_r.nf_src.mbox1_ecc_unc = 1'b1;
    expect_outputs(2'b00, 3'b000, 2'b01, 1'b0, 1'b0);
    push_step(1);
    expect_outputs(2'b00, 3'b000, 2'b01, 1'b0, 1'b1);
    push_step(1);
    step_r.nf_clr.mbox1_ecc_unc = 1'b1;
    expect_outputs(2'b00, 3'b000, 2'b00, 1'b0, 1'b1);
    push_step(1);

    // Masks are an OR of two draws so that some rows come out quiet
    cur_test = 5;
    step_r.nf_mask = '0;
    lcg_state = 32'h0be5_ee71;
    for (r = 0; r < 12; r++) begin
      step_r.agg_f       = next_rand();
      step_r.agg_f_mask  = next_rand() | next_rand();
      step_r.agg_nf      = next_rand();
      step_r.agg_nf_mask = next_rand() | next_rand();
      expect_outputs(2'b00, 3'b000, 2'b00,
                     masked_any(step_r.agg_f, step_r.agg_f_mask),
                     masked_any(step_r.agg_nf, step_r.agg_nf_mask));
      push_step(1);
    end
  endtask

  task automatic drive_step(input step_t s);
    cfg         = s.cfg;
    ctl         = s.ctl;
    wdt_mask    = s.wdt_mask;
    fatal_src   = s.fatal_src;
    fatal_clr   = s.fatal_clr;
    fatal_mask  = s.fatal_mask;
    nf_src      = s.nf_src;
    nf_clr      = s.nf_clr;
    nf_mask     = s.nf_mask;
    agg_f       = s.agg_f;
    agg_f_mask  = s.agg_f_mask;
    agg_nf      = s.agg_nf;
    agg_nf_mask = s.agg_nf_mask;
  endtask

  task automatic clear_pulses();
    ctl       = '0;
    fatal_src = '0;
    fatal_clr = '0;
    nf_src    = '0;
    nf_clr    = '0;
  endtask

  task automatic note_error();
    err_cnt++;
    test_errs++;
  endtask

  task automatic check_step(input step_t s, input int idx);
    assert (wdt_status === s.exp_wdt) else begin
      $display("ERR wdt_status_o step %0d: expected %h got %h", idx, s.exp_wdt, wdt_status);
      note_error();
    end
    assert (fatal_status === s.exp_fatal) else begin
      $display("ERR hw_fatal_status_o step %0d: expected %h got %h",
               idx, s.exp_fatal, fatal_status);
      note_error();
    end
    assert (nf_status === s.exp_nf) else begin
      $display("ERR hw_non_fatal_status_o step %0d: expected %h got %h",
               idx, s.exp_nf, nf_status);
      note_error();
    end
    assert (all_fatal === s.exp_all_f) else begin
      $display("ERR all_error_fatal_o step %0d: expected %h got %h",
               idx, s.exp_all_f, all_fatal);
      note_error();
    end
    assert (all_nf === s.exp_all_nf) else begin
      $display("ERR all_error_non_fatal_o step %0d: expected %h got %h",
               idx, s.exp_all_nf, all_nf);
      note_error();
    end
    check_cnt   += 5;
    test_checks += 5;
  endtask

  task automatic report_test(input int id);
    test_cnt++;
    if (test_errs == 0) begin
      $display("test %0d %s: ok, %0d checks", id, test_name(id), test_checks);
    end else begin
      $display("test %0d %s: FAILED, %0d of %0d checks wrong",
               id, test_name(id), test_errs, test_checks);
      failed_tests++;
    end
    test_errs   = 0;
    test_checks = 0;
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    step_t s;
    int    i;
    int    c;
    rst_n        = 1'b0;
    table_built  = 1'b0;
    total_cycles = 0;
    err_cnt      = 0;
    check_cnt    = 0;
    test_errs    = 0;
    test_checks  = 0;
    test_cnt     = 0;
    failed_tests = 0;
    lcg_state    = 32'h0be5_ee71;
    s            = '0;
    drive_step(s);
    build_table();
    table_built = 1'b1;

    repeat (3) @(posedge core_clk);
    @(negedge core_clk);
    rst_n = 1'b1;

    for (i = 0; i < step_q.size(); i++) begin
      s = step_q[i];
      drive_step(s);
      for (c = 0; c < int'(s.wait_cycles); c++) begin
        @(posedge core_clk);
        @(negedge core_clk);
        if (c == 0) begin
          clear_pulses();
        end
      end
      check_step(s, i);
      if (i == step_q.size() - 1 || step_q[i + 1].test_id != s.test_id) begin
        report_test(int'(s.test_id));
      end
    end

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             test_cnt, failed_tests, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Time limit scales with the table length
  initial begin
    wait (table_built);
    #((total_cycles + 100) * clk_period_ns);
    $display("Timeout: the table did not finish within %0d cycles", total_cycles + 100);
    $display("Regression failed");
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+hw
hw/mci_pkg.sv
hw/mci_wdt.sv
hw/mci_err_capture.sv
hw/mci_err_agg.sv
hw/mci_top.sv
bench/mci_tb_clk.sv
bench/mci_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
# Run from anywhere; paths are relative to the project root.

cd "$(dirname "$0")" || exit 1

rm -f sim.log && \
verilator --binary --timing --assert -f flist.f --top-module mci_tb -o mci_tb_sim && \
./obj_dir/mci_tb_sim 2>&1 | tee sim.log

grep -qx "Regression passed" sim.log && echo "run.sh: simulation ok" || {
  echo "run.sh: simulation did not pass"
  exit 1
}
